// File: bench/fetch_sva.sv
`timescale 1ns/10ps

// valid/ready offer checks, bound once per handshake
module fetch_sva #(
    parameter int W = 32
) (
    input logic         clk,
    input logic         reset,
    input logic         valid,
    input logic         ready,
    input logic         cancel,
    input logic [W-1:0] payload
);
    int fail_cnt = 0;

    // stalled offer holds until taken, unless a redirect withdraws it
    a_hold: assert property (@(posedge clk) disable iff (reset)
        valid && !ready && !cancel |=> cancel || (valid && $stable(payload)))
        else begin
            fail_cnt++;
            $error("offer changed or dropped before it was accepted");
        end

    a_known: assert property (@(posedge clk) disable iff (reset)
        valid |-> !$isunknown(payload))
        else begin
            fail_cnt++;
            $error("offer carries unknown bits");
        end

endmodule

// request address held until addr_ok
bind ibus_port fetch_sva #(.W(32)) u_req_sva (
    .clk     (clk),
    .reset   (reset),
    .valid   (ireq.valid),
    .ready   (iresp.addr_ok),
    .cancel  (pc.redirect),
    .payload (ireq.addr)
);

// decode output stable while out_ready is low
bind slot_align fetch_sva #(.W(2 * $bits(cpu_types_pkg::fetch_slot_t))) u_out_sva (
    .clk     (clk),
    .reset   (reset),
    .valid   (out_valid),
    .ready   (out_ready),
    .cancel  (slot.flush),
    .payload (out_slot)
);

// File: bench/fetch_tb.sv
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetch_tb;
    import cpu_types_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_XFERS    = 600;
    // generous per-transfer bound, stalls and redirects included
    localparam int MAX_LAT      = 40;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_XFERS * MAX_LAT) * CLK_PERIOD;

    logic       clk, reset;
    logic       ireq_valid, iresp_addr_ok, iresp_data_ok;
    word_t      ireq_addr;
    line_t      iresp_data;
    logic       branch_taken, exc_taken, eret_taken;
    word_t      branch_target, epc;
    logic       out_ready, out_valid, out_badaddr;
    logic [1:0] out_slot_valid;
    word_t      out_pc0, out_pc1, out_instr0, out_instr1;

    // reference model and bus responder state
    word_t      exp_pc, acc_addr, rng, rnd_a, rnd_b;
    logic       busy, first_acc;
    int         addr_cnt, data_cnt, xfers, mismatch_cnt, other_cnt;
    string      label;

    fetch_frontend u_dut (.*);

    function automatic word_t xorshift32(input word_t s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    // fixed scramble of the whole word address
    function automatic word_t mem_word(input word_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5bd1_e995;
    endfunction

    // aligned pair, upper half is the word at base+4
    function automatic line_t mem_line(input word_t a);
        return {mem_word({a[31:3], 3'b100}), mem_word({a[31:3], 3'b000})};
    endfunction

    function automatic int sva_fails();
        return u_dut.u_ibus_port.u_req_sva.fail_cnt + u_dut.u_slot_align.u_out_sva.fail_cnt;
    endfunction

    task automatic check_value(input string what, input word_t exp, input word_t act);
        assert (act === exp) else begin
            mismatch_cnt++;
            $display("MISMATCH %s %s: expected %h, actual %h", label, what, exp, act);
        end
    endtask

    task automatic check_transfer();
        logic bad;
        bad = (exp_pc[1:0] != 2'b00);
        check_value("pc0", exp_pc, out_pc0);
        check_value("badaddr", {31'd0, bad}, {31'd0, out_badaddr});
        if (bad) begin
            check_value("instr0", 32'd0, out_instr0);
            check_value("slot_valid", 32'd1, {30'd0, out_slot_valid});
        end else if (exp_pc[2]) begin
            check_value("instr0", mem_word(exp_pc), out_instr0);
            check_value("slot_valid", 32'd1, {30'd0, out_slot_valid});
        end else begin
            check_value("instr0", mem_word(exp_pc), out_instr0);
            check_value("slot_valid", 32'd3, {30'd0, out_slot_valid});
            check_value("pc1", exp_pc + 32'd4, out_pc1);
            check_value("instr1", mem_word(exp_pc + 32'd4), out_instr1);
        end
    endtask

    // one-cycle redirect pulses; exceptions and eret are rare
    task automatic drive_redirect(input word_t r, input word_t t);
        branch_taken <= 1'b0;
        exc_taken    <= 1'b0;
        eret_taken   <= 1'b0;
        if (r[7:0] == 8'd0) begin
            exc_taken     <= 1'b1;
            branch_taken  <= r[8];
            branch_target <= {t[31:2], 2'b00};
        end else if (r[7:0] == 8'd1) begin
            eret_taken <= 1'b1;
            epc        <= {t[31:2], 2'b00};
        end else if (r[4:0] == 5'd2) begin
            branch_taken  <= 1'b1;
            // about one target in eight is misaligned
            branch_target <= (r[10:8] == 3'd0) ? {t[31:2], t[1], 1'b1} : {t[31:2], 2'b00};
        end
    endtask

    task automatic print_counts();
        $display("transfers %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 xfers, mismatch_cnt, other_cnt, sva_fails());
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        rng   = xorshift32(rng);
        rnd_a = rng;
        rng   = xorshift32(rng);
        rnd_b = rng;
        if (reset) begin
            assert (out_valid !== 1'b1) else begin
                other_cnt++;
                $display("out_valid went high while reset was asserted");
            end
            assert (ireq_valid !== 1'b1) else begin
                other_cnt++;
                $display("ireq_valid went high while reset was asserted");
            end
            exp_pc    = `RESET_PC;
            busy      = 1'b0;
            first_acc = 1'b1;
            addr_cnt  = 0;
            label     = "seq_stream";
            iresp_addr_ok <= 1'b0;
            iresp_data_ok <= 1'b0;
            out_ready     <= 1'b0;
        end else begin
            assert (!(ireq_valid && ireq_addr[1:0] != 2'b00)) else begin
                other_cnt++;
                $display("bus request issued for misaligned address %h", ireq_addr);
            end
            // bus responder, one request outstanding
            if (iresp_data_ok) begin
                busy = 1'b0;
            end
            if (ireq_valid && iresp_addr_ok) begin
                if (first_acc) begin
                    check_value("first_addr", `RESET_PC, ireq_addr);
                end
                first_acc = 1'b0;
                busy      = 1'b1;
                acc_addr  = ireq_addr;
                addr_cnt  = rnd_b[1:0];
                data_cnt  = rnd_b[3:2];
            end
            iresp_addr_ok <= 1'b0;
            iresp_data_ok <= 1'b0;
            if (busy && data_cnt == 0) begin
                iresp_data_ok <= 1'b1;
                iresp_data    <= mem_line(acc_addr);
            end else if (busy) begin
                data_cnt--;
            end else if (addr_cnt == 0) begin
                iresp_addr_ok <= 1'b1;
            end else begin
                addr_cnt--;
            end
            // decode side transfer, then any redirect sampled on this edge
            if (out_valid && out_ready) begin
                check_transfer();
                xfers++;
                exp_pc = exp_pc[2] ? exp_pc + 32'd4 : exp_pc + 32'd8;
            end
            if (exc_taken) begin
                exp_pc = `EXC_ENTRY;
                label  = branch_taken ? "exc_with_branch" : "exception";
            end else if (eret_taken) begin
                exp_pc = epc;
                label  = "eret";
            end else if (branch_taken) begin
                exp_pc = branch_target;
                label  = (branch_target[1:0] != 2'b00) ? "misaligned_target" : "branch";
            end
            if (!first_acc) begin
                drive_redirect(rnd_a, xorshift32(rnd_b));
            end
            out_ready <= (rnd_b[5:4] != 2'b00);
        end
    end

    initial begin
        rng           = 32'hb03a462b;
        xfers         = 0;
        mismatch_cnt  = 0;
        other_cnt     = 0;
        reset         = 1'b1;
        iresp_addr_ok = 1'b0;
        iresp_data_ok = 1'b0;
        iresp_data    = '0;
        branch_taken  = 1'b0;
        branch_target = '0;
        exc_taken     = 1'b0;
        eret_taken    = 1'b0;
        epc           = '0;
        out_ready     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        wait (xfers >= NUM_XFERS);
        @(posedge clk);
        print_counts();
        if (mismatch_cnt == 0 && other_cnt == 0 && sva_fails() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        other_cnt++;
        $display("timeout, only %0d of %0d transfers delivered", xfers, NUM_XFERS);
        print_counts();
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+src
src/cpu_types_pkg.sv
src/bus_pkg.sv
src/fetch_ifs.sv
src/pc_gen.sv
src/ibus_port.sv
src/slot_align.sv
src/fetch_frontend.sv
bench/fetch_sva.sv
bench/fetch_tb.sv

// File: src/bus_pkg.sv
package bus_pkg;

    import cpu_types_pkg::*;

    // held until addr_ok
    typedef struct packed {
        logic  valid;
        word_t addr;
    } ibus_req_t;

    // data_ok comes one or more cycles after addr_ok
    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        line_t data;
    } ibus_resp_t;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_ADDR,
        BUS_DATA,
        BUS_HOLD
    } ibus_state_t;

endpackage

// File: src/cpu_types_pkg.sv
package cpu_types_pkg;

    `include "fetch_defs.svh"

    // instruction or address word
    typedef logic [`WORD_W-1:0] word_t;

    // fetched pair, lower half is the even word
    typedef logic [`LINE_W-1:0] line_t;

    // where the next pc comes from
    typedef enum logic [1:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_ERET,
        PC_EXC
    } pc_src_t;

    // one decoded-side instruction slot
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
        // pc was not word aligned
        logic  badaddr;
    } fetch_slot_t;

endpackage

// File: src/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// pc after reset, boot rom base
`define RESET_PC 32'hbfc0_0000

// general exception entrance
`define EXC_ENTRY 32'hbfc0_0380

// one instruction word
`define WORD_W 32

// one fetch returns an aligned pair of words
`define LINE_W 64

`endif

// File: src/fetch_frontend.sv
`timescale 1ns/10ps

module fetch_frontend (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 ireq_valid,
    output cpu_types_pkg::word_t ireq_addr,
    input  logic                 iresp_addr_ok,
    input  logic                 iresp_data_ok,
    input  cpu_types_pkg::line_t iresp_data,
    input  logic                 branch_taken,
    input  cpu_types_pkg::word_t branch_target,
    input  logic                 exc_taken,
    input  logic                 eret_taken,
    input  cpu_types_pkg::word_t epc,
    input  logic                 out_ready,
    output logic                 out_valid,
    output logic [1:0]           out_slot_valid,
    output cpu_types_pkg::word_t out_pc0,
    output cpu_types_pkg::word_t out_pc1,
    output cpu_types_pkg::word_t out_instr0,
    output cpu_types_pkg::word_t out_instr1,
    output logic                 out_badaddr
);
    import cpu_types_pkg::*;
    import bus_pkg::*;

    ibus_req_t         ireq;
    ibus_resp_t        iresp;
    fetch_slot_t [1:0] out_slot;

    pc_if   pc_link ();
    slot_if slot_link ();

    pc_gen u_pc_gen (
        .clk           (clk),
        .reset         (reset),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .exc_taken     (exc_taken),
        .eret_taken    (eret_taken),
        .epc           (epc),
        .pc            (pc_link.gen)
    );

    ibus_port u_ibus_port (
        .clk   (clk),
        .reset (reset),
        .ireq  (ireq),
        .iresp (iresp),
        .pc    (pc_link.port),
        .slot  (slot_link.src)
    );

    slot_align u_slot_align (
        .clk       (clk),
        .reset     (reset),
        .slot      (slot_link.dst),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_slot  (out_slot)
    );

    // bus structs to flat pins
    assign ireq_valid    = ireq.valid;
    assign ireq_addr     = ireq.addr;
    assign iresp.addr_ok = iresp_addr_ok;
    assign iresp.data_ok = iresp_data_ok;
    assign iresp.data    = iresp_data;

    assign out_slot_valid = {out_slot[1].valid, out_slot[0].valid};
    assign out_pc0        = out_slot[0].pc;
    assign out_pc1        = out_slot[1].pc;
    assign out_instr0     = out_slot[0].instr;
    assign out_instr1     = out_slot[1].instr;
    // only slot 0 can carry a bad address
    assign out_badaddr    = out_slot[0].badaddr;

endmodule

// File: src/fetch_ifs.sv
`timescale 1ns/10ps

// pc handoff from pc_gen to ibus_port
interface pc_if;
    import cpu_types_pkg::*;

    word_t pc;
    // low for a pc that is not word aligned
    logic  pc_valid;
    // a redirect input was sampled this cycle
    logic  redirect;
    // port has consumed the current pc
    logic  take;

    modport gen (
        output pc,
        output pc_valid,
        output redirect,
        input  take
    );

    modport port (
        input  pc,
        input  pc_valid,
        input  redirect,
        output take
    );
endinterface

// fetched line from ibus_port to slot_align
interface slot_if;
    import cpu_types_pkg::*;

    logic  valid;
    logic  ready;
    word_t pc;
    line_t data;
    logic  badaddr;
    // drops whatever slot_align holds
    logic  flush;

    modport src (
        output valid,
        output pc,
        output data,
        output badaddr,
        output flush,
        input  ready
    );

    modport dst (
        input  valid,
        input  pc,
        input  data,
        input  badaddr,
        input  flush,
        output ready
    );
endinterface

// File: src/ibus_port.sv
`timescale 1ns/10ps

module ibus_port (
    input  logic                clk,
    input  logic                reset,
    output bus_pkg::ibus_req_t  ireq,
    input  bus_pkg::ibus_resp_t iresp,
    pc_if.port                  pc,
    slot_if.src                 slot
);
    import cpu_types_pkg::*;
    import bus_pkg::*;

    ibus_state_t state;
    ibus_state_t state_nxt;
    logic        issue;
    logic        req_fire;
    logic        bad_fire;
    logic        bad_start;
    logic        discard;
    word_t       hold_pc;
    line_t       hold_data;
    logic        hold_bad;

    // request shown from IDLE, held in ADDR, withdrawn on redirect, off in reset
    assign issue      = (state == BUS_IDLE || state == BUS_ADDR) && !pc.redirect && !reset;
    assign ireq.valid = issue && pc.pc_valid;
    assign ireq.addr  = pc.pc;
    assign req_fire   = ireq.valid && iresp.addr_ok;

    // misaligned pc skips the bus entirely
    assign bad_start = issue && !pc.pc_valid;
    assign bad_fire  = (state == BUS_HOLD) && hold_bad && slot.ready && !pc.redirect;

    assign pc.take = req_fire || bad_fire;

    always_comb begin
        state_nxt = state;
        case (state)
            BUS_IDLE, BUS_ADDR: begin
                if (pc.redirect) begin
                    state_nxt = BUS_IDLE;
                end else if (!pc.pc_valid) begin
                    state_nxt = BUS_HOLD;
                end else if (iresp.addr_ok) begin
                    state_nxt = BUS_DATA;
                end else begin
                    state_nxt = BUS_ADDR;
                end
            end
            BUS_DATA: begin
                // a response for a redirected fetch is dropped here
                if (iresp.data_ok) begin
                    state_nxt = (discard || pc.redirect) ? BUS_IDLE : BUS_HOLD;
                end
            end
            BUS_HOLD: begin
                if (pc.redirect || slot.ready) begin
                    state_nxt = BUS_IDLE;
                end
            end
            default: state_nxt = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= BUS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // only one request outstanding, so one flag is enough
    always_ff @(posedge clk) begin
        if (reset) begin
            discard <= 1'b0;
        end else if (state == BUS_DATA) begin
            if (iresp.data_ok) begin
                discard <= 1'b0;
            end else if (pc.redirect) begin
                discard <= 1'b1;
            end
        end
    end

    // pc advances at take, so keep the one that was fetched
    always_ff @(posedge clk) begin
        if (req_fire) begin
            hold_pc  <= pc.pc;
            hold_bad <= 1'b0;
        end else if (bad_start) begin
            hold_pc  <= pc.pc;
            hold_bad <= 1'b1;
        end
        if (state == BUS_DATA && iresp.data_ok) begin
            hold_data <= iresp.data;
        end
    end

    assign slot.valid   = (state == BUS_HOLD);
    assign slot.pc      = hold_pc;
    assign slot.data    = hold_data;
    assign slot.badaddr = hold_bad;
    assign slot.flush   = pc.redirect;

endmodule

// File: src/pc_gen.sv
`timescale 1ns/10ps
`include "fetch_defs.svh"

module pc_gen (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 branch_taken,
    input  cpu_types_pkg::word_t branch_target,
    input  logic                 exc_taken,
    input  logic                 eret_taken,
    input  cpu_types_pkg::word_t epc,
    pc_if.gen                    pc
);
    import cpu_types_pkg::*;

    word_t   pc_q;
    word_t   pc_seq;
    word_t   pc_target;
    pc_src_t pc_src;

    // odd word of a pair steps by one word, otherwise by the pair
    always_comb begin
        if (pc_q[2]) begin
            pc_seq = pc_q + 32'd4;
        end else begin
            pc_seq = pc_q + 32'd8;
        end
    end

    // fixed priority, exception first
    always_comb begin
        if (exc_taken) begin
            pc_src = PC_EXC;
        end else if (eret_taken) begin
            pc_src = PC_ERET;
        end else if (branch_taken) begin
            pc_src = PC_BRANCH;
        end else begin
            pc_src = PC_SEQ;
        end
    end

    always_comb begin
        case (pc_src)
            PC_EXC:    pc_target = `EXC_ENTRY;
            PC_ERET:   pc_target = epc;
            PC_BRANCH: pc_target = branch_target;
            default:   pc_target = pc_seq;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `RESET_PC;
        end else if (exc_taken || eret_taken) begin
            pc_q <= pc_target;
        end else if (pc.take) begin
            pc_q <= pc_seq;
        end else if (pc.redirect) begin
            pc_q <= pc_target;
        end
    end

    assign pc.pc       = pc_q;
    assign pc.pc_valid = (pc_q[1:0] == 2'b00);
    assign pc.redirect = (pc_src != PC_SEQ);

endmodule

// File: src/slot_align.sv
`timescale 1ns/10ps

module slot_align (
    input  logic                              clk,
    input  logic                              reset,
    slot_if.dst                               slot,
    input  logic                              out_ready,
    output logic                              out_valid,
    output cpu_types_pkg::fetch_slot_t [1:0]  out_slot
);
    import cpu_types_pkg::*;

    fetch_slot_t [1:0] slot_nxt;
    logic              load;

    // plain pipeline register handshake
    assign slot.ready = !out_valid || out_ready;
    assign load       = slot.valid && slot.ready && !slot.flush;

    always_comb begin
        // slot 0 is the word at pc
        slot_nxt[0].valid   = 1'b1;
        slot_nxt[0].pc      = slot.pc;
        slot_nxt[0].badaddr = slot.badaddr;
        if (slot.badaddr) begin
            slot_nxt[0].instr = '0;
        end else if (slot.pc[2]) begin
            slot_nxt[0].instr = slot.data[63:32];
        end else begin
            slot_nxt[0].instr = slot.data[31:0];
        end

        // slot 1 only when pc sits on the even word
        slot_nxt[1].valid   = !slot.badaddr && !slot.pc[2];
        slot_nxt[1].pc      = slot.pc + 32'd4;
        slot_nxt[1].instr   = slot.data[63:32];
        slot_nxt[1].badaddr = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (slot.flush) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // held as is while out_ready is low
    always_ff @(posedge clk) begin
        if (reset || slot.flush) begin
            out_slot[0].valid <= 1'b0;
            out_slot[1].valid <= 1'b0;
        end else if (load) begin
            out_slot <= slot_nxt;
        end
    end

endmodule
